// ==== hdl/dsp_mac_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

// behavioral multiply-add slice standing in for a dsp48 style core
module dsp_mac_slice #(
   parameter type operand_t = smac_pkg::op8_t  // sets a, b, c and p width
) (
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  wire logic           ce,     // lane enable
   input  wire logic           sclr,   // sync clear that beats ce
   input  wire operand_t       a,      // data operand
   input  wire operand_t       b,      // weight operand
   input  wire operand_t       c,      // addend from previous stage
   input  wire smac_pkg::acc_t pcin,   // cascade from lane below
   output operand_t            p,      // lane result
   output smac_pkg::acc_t      pcout   // cascade to lane above
);

   localparam int OP_W = $bits(operand_t);  // operand width in bits

   logic [2*OP_W-1:0] prod;   // full width product
   smac_pkg::acc_t    acc_d;  // next accumulator value
   smac_pkg::acc_t    acc_q;  // accumulator register

   ////////////////////////////// multiply-add
   assign prod  = a * b;                        // unsigned with no overflow at 2x width
   assign acc_d = smac_pkg::acc_t'(prod)        // 32x32 product drops top bits
                + smac_pkg::acc_t'(c)           // zero extended addend
                + pcin;                         // wraps mod 2^48

   ////////////////////////////// accumulator register
   always_ff @(posedge clk) begin
      if (!rst_n || sclr) begin
         acc_q <= '0;                           // clear wins over ce
      end else if (ce) begin
         acc_q <= acc_d;                        // load on enable
      end                                       // otherwise hold
   end

   ////////////////////////////// outputs
   assign p     = acc_q[OP_W-1:0];              // low lane bits only
   assign pcout = acc_q;                        // full word up the chain

endmodule

`default_nettype wire

// ==== hdl/smac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smac_cfg.svh"

// sub-mac lane array with 8/8/16/32 split and gated cascade
module smac (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic                  ce,                // global clock enable
   input  wire logic                  sclr,              // clears every lane
   input  wire logic                  active_chain,      // opens cascade links
   input  wire smac_pkg::lane_sel_t   select_precision,  // per lane enable mask
   input  wire logic [`SMAC_VEC_W-1:0] data_input,
   input  wire logic [`SMAC_VEC_W-1:0] weight,
   input  wire logic [`SMAC_VEC_W-1:0] res_mac_p,        // addends from prev stage
   output logic [`SMAC_VEC_W-1:0]      res_mac_n,        // lane results
   output smac_pkg::acc_t             chain_out          // lane 3 cascade
);

   smac_pkg::lane_sel_t lane_en;                       // ce and select per lane
   smac_pkg::acc_t      pcout [0:`SMAC_NUM_LANES-1];   // raw cascade outputs
   smac_pkg::acc_t      pcin  [1:`SMAC_NUM_LANES-1];   // gated cascade inputs

   ////////////////////////////// enable network
   assign lane_en = select_precision & {`SMAC_NUM_LANES{ce}};  // lane k needs both

   ////////////////////////////// cascade gating
   for (genvar k = 1; k < `SMAC_NUM_LANES; k++) begin : g_link
      assign pcin[k] = active_chain ? pcout[k-1] : '0; // zero unless chaining
   end

   assign chain_out = pcout[`SMAC_NUM_LANES-1];        // out to next unit

   ////////////////////////////// lanes
   dsp_mac_slice #(.operand_t(smac_pkg::op8_t)) slice_8_0 (
      .clk   (clk),
      .rst_n (rst_n),
      .ce    (lane_en[0]),
      .sclr  (sclr),
      .a     (data_input[`SMAC_LANE0_LSB +: `SMAC_LANE0_W]),
      .b     (weight[`SMAC_LANE0_LSB +: `SMAC_LANE0_W]),
      .c     (res_mac_p[`SMAC_LANE0_LSB +: `SMAC_LANE0_W]),
      .pcin  ('0),                                     // bottom lane has no source
      .p     (res_mac_n[`SMAC_LANE0_LSB +: `SMAC_LANE0_W]),
      .pcout (pcout[0])
   );

   dsp_mac_slice #(.operand_t(smac_pkg::op8_t)) slice_8_1 (
      .clk   (clk),
      .rst_n (rst_n),
      .ce    (lane_en[1]),
      .sclr  (sclr),
      .a     (data_input[`SMAC_LANE1_LSB +: `SMAC_LANE1_W]),
      .b     (weight[`SMAC_LANE1_LSB +: `SMAC_LANE1_W]),
      .c     (res_mac_p[`SMAC_LANE1_LSB +: `SMAC_LANE1_W]),
      .pcin  (pcin[1]),                                // from slice_8_0
      .p     (res_mac_n[`SMAC_LANE1_LSB +: `SMAC_LANE1_W]),
      .pcout (pcout[1])
   );

   dsp_mac_slice #(.operand_t(smac_pkg::op16_t)) slice_16 (
      .clk   (clk),
      .rst_n (rst_n),
      .ce    (lane_en[2]),
      .sclr  (sclr),
      .a     (data_input[`SMAC_LANE2_LSB +: `SMAC_LANE2_W]),
      .b     (weight[`SMAC_LANE2_LSB +: `SMAC_LANE2_W]),
      .c     (res_mac_p[`SMAC_LANE2_LSB +: `SMAC_LANE2_W]),
      .pcin  (pcin[2]),                                // from slice_8_1
      .p     (res_mac_n[`SMAC_LANE2_LSB +: `SMAC_LANE2_W]),
      .pcout (pcout[2])
   );

   dsp_mac_slice #(.operand_t(smac_pkg::op32_t)) slice_32 (
      .clk   (clk),
      .rst_n (rst_n),
      .ce    (lane_en[3]),
      .sclr  (sclr),
      .a     (data_input[`SMAC_LANE3_LSB +: `SMAC_LANE3_W]),
      .b     (weight[`SMAC_LANE3_LSB +: `SMAC_LANE3_W]),
      .c     (res_mac_p[`SMAC_LANE3_LSB +: `SMAC_LANE3_W]),
      .pcin  (pcin[3]),                                // from slice_16
      .p     (res_mac_n[`SMAC_LANE3_LSB +: `SMAC_LANE3_W]),
      .pcout (pcout[3])
   );

endmodule

`default_nettype wire

// ==== hdl/smac_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smac_cfg.svh"

// apb slave holding the ctrl register and clear strobe
module smac_apb_regs (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire logic [`SMAC_APB_AW-1:0] paddr,
   input  wire logic [`SMAC_APB_DW-1:0] pwdata,
   output logic [`SMAC_APB_DW-1:0]      prdata,
   output logic                        pready,
   output logic                        pslverr,
   output logic                        active_chain,
   output logic                        sclr,
   output smac_pkg::lane_sel_t         select_precision
);

   logic                access;     // access phase of a transfer
   logic                hit_ctrl;   // ctrl decode
   logic                hit_cmd;    // cmd decode
   logic                wr_ctrl;    // ctrl write strobe
   logic                wr_clr;     // cmd write with bit 0 set
   logic [`SMAC_APB_DW-1:0] ctrl_rd; // ctrl readback word
   smac_pkg::lane_sel_t sel_q;      // ctrl bits 3:0
   logic                chain_q;    // ctrl bit 4
   logic                sclr_q;     // registered clear pulse

   ////////////////////////////// decode
   assign access   = psel & penable;
   assign hit_ctrl = (paddr == `SMAC_ADDR_CTRL);
   assign hit_cmd  = (paddr == `SMAC_ADDR_CMD);
   assign wr_ctrl  = access & pwrite & hit_ctrl;
   assign wr_clr   = access & pwrite & hit_cmd & pwdata[0];

   ////////////////////////////// registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sel_q   <= '0;                               // all lanes off
         chain_q <= 1'b0;                             // cascade off
         sclr_q  <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            sel_q   <= pwdata[`SMAC_NUM_LANES-1:0];   // lane mask
            chain_q <= pwdata[`SMAC_NUM_LANES];       // chain enable
         end
         sclr_q <= wr_clr;                            // high one cycle per write
      end
   end

   ////////////////////////////// read path and response
   assign ctrl_rd = {{(`SMAC_APB_DW-`SMAC_NUM_LANES-1){1'b0}}, chain_q, sel_q};
   assign prdata  = (access && !pwrite && hit_ctrl) ? ctrl_rd : '0;  // cmd reads 0
   assign pready  = 1'b1;                             // never stalls
   assign pslverr = access & ~(hit_ctrl | hit_cmd);   // unmapped address

   ////////////////////////////// control outputs
   assign select_precision = sel_q;
   assign active_chain     = chain_q;
   assign sclr             = sclr_q;

endmodule

`default_nettype wire

// ==== hdl/smac_cfg.svh ====
`ifndef SMAC_CFG_SVH
`define SMAC_CFG_SVH

////////////////////////////// datapath widths
`define SMAC_VEC_W        64    // data_input, weight, res_mac_p, res_mac_n
`define SMAC_ACC_W        48    // cascade and accumulator word
`define SMAC_NUM_LANES    4     // lanes in the array

////////////////////////////// lane split 8/8/16/32
`define SMAC_LANE0_W      8     // low byte lane
`define SMAC_LANE1_W      8     // second byte lane
`define SMAC_LANE2_W      16    // halfword lane
`define SMAC_LANE3_W      32    // word lane driving chain_out
`define SMAC_LANE0_LSB    0     // offsets into the vector
`define SMAC_LANE1_LSB    8
`define SMAC_LANE2_LSB    16
`define SMAC_LANE3_LSB    32

////////////////////////////// apb map
`define SMAC_APB_AW       4     // byte address bits
`define SMAC_APB_DW       32    // data bus width
`define SMAC_ADDR_CTRL    4'h0  // rw lane select and chain enable
`define SMAC_ADDR_CMD     4'h4  // write only clear strobe

`endif

// ==== hdl/smac_pkg.sv ====
`default_nettype none

`include "smac_cfg.svh"

package smac_pkg;

   ////////////////////////////// lane operands
   // unsigned operands with one type per lane width
   typedef logic [`SMAC_LANE0_W-1:0] op8_t;   // lanes 0 and 1
   typedef logic [`SMAC_LANE2_W-1:0] op16_t;  // lane 2
   typedef logic [`SMAC_LANE3_W-1:0] op32_t;  // lane 3

   ////////////////////////////// accumulator
   // shared by the slice register and the cascade links
   typedef logic [`SMAC_ACC_W-1:0] acc_t;

   ////////////////////////////// control
   // bit k enables lane k
   typedef logic [`SMAC_NUM_LANES-1:0] lane_sel_t;

endpackage

`default_nettype wire

// ==== hdl/smac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smac_cfg.svh"

// register block driving the sub-mac lane array
module smac_top (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire logic [`SMAC_APB_AW-1:0] paddr,
   input  wire logic [`SMAC_APB_DW-1:0] pwdata,
   output logic [`SMAC_APB_DW-1:0]      prdata,
   output logic                        pready,
   output logic                        pslverr,
   input  wire logic                   ce,
   input  wire logic [`SMAC_VEC_W-1:0]  data_input,
   input  wire logic [`SMAC_VEC_W-1:0]  weight,
   input  wire logic [`SMAC_VEC_W-1:0]  res_mac_p,
   output logic [`SMAC_VEC_W-1:0]       res_mac_n,
   output smac_pkg::acc_t              chain_out
);

   smac_pkg::lane_sel_t select_precision;  // ctrl[3:0]
   logic                active_chain;      // ctrl[4]
   logic                sclr;              // cmd strobe

   smac_apb_regs u_regs (
      .clk              (clk),
      .rst_n            (rst_n),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr),
      .active_chain     (active_chain),
      .sclr             (sclr),
      .select_precision (select_precision)
   );

   smac u_smac (
      .clk              (clk),
      .rst_n            (rst_n),
      .ce               (ce),
      .sclr             (sclr),
      .active_chain     (active_chain),
      .select_precision (select_precision),
      .data_input       (data_input),
      .weight           (weight),
      .res_mac_p        (res_mac_p),
      .res_mac_n        (res_mac_n),
      .chain_out        (chain_out)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the smac testbench with Verilator.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module smac_tb -f sim.f -Mdir "$OBJ_DIR" -o smac_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ_DIR/smac_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1

// ==== sim.f ====
+incdir+hdl
hdl/smac_pkg.sv
hdl/dsp_mac_slice.sv
hdl/smac.sv
hdl/smac_apb_regs.sv
hdl/smac_top.sv
sim/smac_assertions.sv
sim/smac_tb.sv

// ==== sim/smac_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smac_cfg.svh"

// protocol and datapath properties bound into smac_top
module smac_assertions (
   input wire logic                   clk,
   input wire logic                   rst_n,
   input wire logic                   psel,
   input wire logic                   penable,
   input wire logic                   pslverr,
   input wire logic                   sclr,
   input wire logic                   ce,
   input wire logic [`SMAC_VEC_W-1:0] res_mac_n
);

   ////////////////////////////// apb response
   a_pslverr_in_access : assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> (psel && penable))                  // error only in access phase
      else $error("pslverr high outside an access cycle");

   ////////////////////////////// clear strobe
   a_clear_zeroes : assert property (@(posedge clk) disable iff (!rst_n)
      sclr |=> (res_mac_n == '0))                     // every lane zero next cycle
      else $error("res_mac_n not zero after sclr");

   ////////////////////////////// stall
   // word lane must not move on an edge with ce low
   a_lane3_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (!ce && !sclr) |=> $stable(res_mac_n[`SMAC_LANE3_LSB +: `SMAC_LANE3_W]))
      else $error("lane 3 of res_mac_n changed while ce was low");

endmodule

bind smac_top smac_assertions u_smac_assertions (
   .clk       (clk),
   .rst_n     (rst_n),
   .psel      (psel),
   .penable   (penable),
   .pslverr   (pslverr),
   .sclr      (sclr),                                 // internal strobe of smac_top
   .ce        (ce),
   .res_mac_n (res_mac_n)
);

`default_nettype wire

// ==== sim/smac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smac_cfg.svh"

module smac_tb;

   typedef struct packed {
      logic [4:0]  ctrl;       // chain enable + lane mask
      logic        clr;        // cmd write before the row
      logic        ce;
      logic [63:0] din;
      logic [63:0] w;
      logic [63:0] rp;
      logic [63:0] exp_res;
      logic [47:0] exp_chain;
   } row_t;

   localparam int NROWS = 10;
   localparam int NRAND = 200;
   localparam int WATCHDOG_NS = (4 + NROWS * 12 + NRAND * 12 + 40) * 4 * 2;
   localparam logic [63:0] D0 = 64'h00000002_0010_05_03;  // lane a values 2/16/5/3
   localparam logic [63:0] W0 = 64'h00000007_0020_06_04;
   localparam logic [63:0] R0 = 64'h00000009_0003_02_01;
   localparam logic [63:0] D6 = 64'h00000002_0010_05_FF;  // lane 0 overflows its byte
   localparam logic [63:0] W6 = 64'h00000007_0020_06_FF;
   localparam logic [63:0] R6 = 64'h00000009_0003_02_02;
   localparam logic [63:0] DF = '1;

   logic clk, rst_n, psel, penable, pwrite, pready, pslverr, ce;
   logic [`SMAC_APB_AW-1:0] paddr;
   logic [`SMAC_APB_DW-1:0] pwdata, prdata;
   logic [`SMAC_VEC_W-1:0]  data_input, weight, res_mac_p, res_mac_n;
   smac_pkg::acc_t          chain_out;

   row_t                tbl [0:NROWS-1];
   smac_pkg::acc_t      m_acc [0:3];           // reference lane accumulators
   smac_pkg::lane_sel_t m_sel;
   logic                m_chain;
   logic [31:0]         rng_state = 32'd39101;
   int                  lane_w   [0:3] = '{8, 8, 16, 32};
   int                  lane_lsb [0:3] = '{0, 8, 16, 32};
   int                  checks = 0;
   int                  errors = 0;

   smac_top u_smac_top (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run did not finish in time");
      $display("TB FAILED");
      $finish;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   ////////////////////////////// reference model
   task automatic model_edge(input logic c, input logic [63:0] d, w, rp);
      smac_pkg::acc_t nxt [0:3];
      smac_pkg::acc_t pcin;
      logic [63:0]    mask, a, b, ad, sum;
      for (int k = 0; k < 4; k++) begin
         mask = (64'd1 << lane_w[k]) - 64'd1;
         a    = (d >> lane_lsb[k]) & mask;
         b    = (w >> lane_lsb[k]) & mask;
         ad   = (rp >> lane_lsb[k]) & mask;
         pcin = (k > 0 && m_chain) ? m_acc[k-1] : '0;   // old value of lane below
         sum  = a * b + ad + {16'd0, pcin};
         nxt[k] = (c && m_sel[k]) ? sum[47:0] : m_acc[k];
      end
      for (int k = 0; k < 4; k++) m_acc[k] = nxt[k];
   endtask

   function automatic logic [63:0] model_res();
      logic [63:0] res;
      res = '0;
      for (int k = 0; k < 4; k++) begin
         res |= (({16'd0, m_acc[k]}) & ((64'd1 << lane_w[k]) - 64'd1)) << lane_lsb[k];
      end
      return res;
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, act);
      checks++;
      assert (act === exp) else begin
         $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   ////////////////////////////// apb
   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;                          // access cycle
      @(negedge clk);
      err = pslverr;
      check_val("pready", 64'd1, {63'd0, pready});  // no wait states
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;                            // valid in access cycle
      err  = pslverr;
      check_val("pready", 64'd1, {63'd0, pready});
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_ctrl(input logic [4:0] v);
      logic err;
      apb_write(`SMAC_ADDR_CTRL, {27'd0, v}, err);
      check_val("pslverr", 64'd0, {63'd0, err});
      m_sel   = v[3:0];
      m_chain = v[4];
   endtask

   task automatic clear_lanes();
      logic err;
      apb_write(`SMAC_ADDR_CMD, 32'h1, err);
      check_val("pslverr", 64'd0, {63'd0, err});
      @(posedge clk);                           // strobe lands here
      for (int k = 0; k < 4; k++) m_acc[k] = '0;
      @(negedge clk);
      check_val("res_mac_n", 64'd0, res_mac_n);
      check_val("chain_out", 64'd0, {16'd0, chain_out});
   endtask

   // one data beat then ce drops so the lanes hold for the check
   task automatic step(input logic c, input logic [63:0] d, w, rp);
      @(posedge clk);
      ce         <= c;
      data_input <= d;
      weight     <= w;
      res_mac_p  <= rp;
      @(posedge clk);
      model_edge(c, d, w, rp);
      ce <= 1'b0;
      @(negedge clk);
   endtask

   task automatic run_rows(input string name, input int first, input int last);
      int err0;
      err0 = errors;
      for (int i = first; i <= last; i++) begin
         if (tbl[i].clr) clear_lanes();
         if (tbl[i].ctrl != {m_chain, m_sel}) write_ctrl(tbl[i].ctrl);
         step(tbl[i].ce, tbl[i].din, tbl[i].w, tbl[i].rp);
         check_val("res_mac_n", tbl[i].exp_res, res_mac_n);
         check_val("chain_out", {16'd0, tbl[i].exp_chain}, {16'd0, chain_out});
      end
      $display("test %s: %s", name, (errors == err0) ? "ok" : "failed");
   endtask

   task automatic load_table();
      tbl[0] = '{5'h05, 1'b0, 1'b1, D0, W0, R0, 64'h00000000_0203_00_0D, 48'h0};
      tbl[1] = '{5'h05, 1'b0, 1'b0, DF, DF, DF, 64'h00000000_0203_00_0D, 48'h0};
      tbl[2] = '{5'h0F, 1'b0, 1'b1, D0, W0, R0, 64'h00000017_0203_20_0D, 48'h17};
      tbl[3] = '{5'h1F, 1'b0, 1'b1, D0, W0, R0, 64'h0000021A_0223_2D_0D, 48'h21A};
      tbl[4] = '{5'h1F, 1'b0, 1'b1, D0, W0, R0, 64'h0000023A_0230_2D_0D, 48'h23A};
      tbl[5] = '{5'h1F, 1'b0, 1'b1, D0, W0, R0, 64'h00000247_0230_2D_0D, 48'h247};
      tbl[6] = '{5'h0F, 1'b0, 1'b1, D6, W6, R6, 64'h00000017_0203_20_03, 48'h17};
      tbl[7] = '{5'h1F, 1'b0, 1'b1, D0, W0, R0, 64'h0000021A_0223_23_0D, 48'h21A};
      tbl[8] = '{5'h1F, 1'b1, 1'b0, D0, W0, R0, 64'h0, 48'h0};
      tbl[9] = '{5'h1F, 1'b0, 1'b1, D0, W0, R0, 64'h00000017_0203_20_0D, 48'h17};
   endtask

   ////////////////////////////// main sequence
   initial begin
      logic [31:0] rd, r;
      logic        err;
      int          err0;
      rst_n      = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      ce         = 1'b0;
      data_input = '0;
      weight     = '0;
      res_mac_p  = '0;
      m_sel      = '0;
      m_chain    = 1'b0;
      for (int k = 0; k < 4; k++) m_acc[k] = '0;
      load_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      err0 = errors;                            // reset values
      check_val("res_mac_n", 64'd0, res_mac_n);
      check_val("chain_out", 64'd0, {16'd0, chain_out});
      check_val("pslverr", 64'd0, {63'd0, pslverr});
      apb_read(`SMAC_ADDR_CTRL, rd, err);
      check_val("prdata", 64'd0, {32'd0, rd});
      $display("test reset: %s", (errors == err0) ? "ok" : "failed");

      err0 = errors;                            // register access and decode error
      apb_write(`SMAC_ADDR_CTRL, 32'hFFFF_FFEA, err);
      apb_read(`SMAC_ADDR_CTRL, rd, err);
      check_val("prdata", 64'h0A, {32'd0, rd});
      apb_write(4'hC, 32'h0000_0015, err);
      check_val("pslverr", 64'd1, {63'd0, err});
      apb_read(`SMAC_ADDR_CTRL, rd, err);
      check_val("prdata", 64'h0A, {32'd0, rd});
      check_val("pslverr", 64'd0, {63'd0, err});
      apb_read(`SMAC_ADDR_CMD, rd, err);       // write only register
      check_val("prdata", 64'd0, {32'd0, rd});
      write_ctrl(5'h00);
      $display("test apb: %s", (errors == err0) ? "ok" : "failed");

      run_rows("lane enables", 0, 1);
      run_rows("cascade", 2, 7);
      run_rows("clear", 8, 9);

      err0 = errors;                            // lcg driven traffic
      for (int i = 0; i < NRAND; i++) begin
         r = lcg_next();
         if (r[3:0] == 4'd0) write_ctrl(r[12:8]);
         if (r[7:4] == 4'd1) clear_lanes();
         step(r[16], {lcg_next(), lcg_next()}, {lcg_next(), lcg_next()},
              {lcg_next(), lcg_next()});
         check_val("res_mac_n", model_res(), res_mac_n);
         check_val("chain_out", {16'd0, m_acc[3]}, {16'd0, chain_out});
      end
      $display("test random: %s", (errors == err0) ? "ok" : "failed");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
